//--- hdl/ntm_math_pkg.sv
// Q4.12 sample format, product width and Taylor coefficients for sinh

package ntm_math_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Element word, 4 integer bits and 12 fraction bits
  localparam int SAMPLE_W = 16;

  // Every intermediate product and sum
  localparam int WIDE_W = 32;

  // Binary point position
  localparam int FRAC_BITS = 12;

  ////////////////////
  // Types
  ////////////////////

  // Signed Q4.12 matrix element
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // Signed product, wraps at 32 bits
  typedef logic signed [WIDE_W-1:0] wide_t;

  ////////////////////
  // Constants
  ////////////////////

  // 1/6 in Q12, rounded
  localparam wide_t C3 = 32'sd683;

  // 1/120 in Q12, rounded
  localparam wide_t C5 = 32'sd34;

  // Saturation limits of the final sum
  localparam sample_t SAMPLE_MAX = 16'sh7FFF;
  localparam sample_t SAMPLE_MIN = 16'sh8000;

endpackage

//--- hdl/ntm_ctrl_pkg.sv
// Configuration word union, register addresses and stream structs

package ntm_ctrl_pkg;

  import ntm_math_pkg::*;

  ////////////////////
  // Configuration
  ////////////////////

  // Matrix dimension, rows or columns
  typedef logic [7:0] dim_t;

  // Register map, one bit of address
  typedef enum logic {
    ADDR_SIZE = 1'b0,
    ADDR_CTRL = 1'b1
  } cfg_addr_t;

  // Same 16 bits, read as sizes or as control
  typedef union packed {
    struct packed {
      dim_t size_i;
      dim_t size_j;
    } size;
    struct packed {
      logic [14:0] rsvd;
      logic        start;
    } ctrl;
  } cfg_word_u;

  // Single-cycle register write
  typedef struct packed {
    logic      valid;
    cfg_addr_t addr;
    cfg_word_u word;
  } cfg_wr_t;

  // Dimensions of the current job
  typedef struct packed {
    dim_t size_i;
    dim_t size_j;
  } job_cfg_t;

  ////////////////////
  // Streams
  ////////////////////

  // Producer side, row-major, no markers
  typedef struct packed {
    logic    valid;
    sample_t data;
  } in_elem_t;

  // Consumer side with row and matrix markers
  typedef struct packed {
    logic    valid;
    sample_t data;
    logic    last_col;
    logic    last_row;
  } out_elem_t;

endpackage

//--- hdl/ntm_sinh_config.sv
// Configuration registers, start command decode and busy tracking

`timescale 1ns/1ps

module ntm_sinh_config
  import ntm_ctrl_pkg::*;
(
  input  logic     CLK,
  input  logic     RST,
  input  cfg_wr_t  cfg_wr,
  input  logic     done,
  output job_cfg_t job_cfg,
  output logic     start,
  output logic     busy
);

  ////////////////////
  // Write decode
  ////////////////////

  logic size_wr;
  logic start_req;

  // Size register write, accepted at any time
  assign size_wr = cfg_wr.valid && (cfg_wr.addr == ADDR_SIZE);

  // Start bit only counts when idle
  assign start_req = cfg_wr.valid && (cfg_wr.addr == ADDR_CTRL) &&
                     cfg_wr.word.ctrl.start && !busy;

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      job_cfg <= '0;
      start   <= 1'b0;
      busy    <= 1'b0;
    end else begin
      // Dimensions through the size view of the word
      if (size_wr) begin
        job_cfg.size_i <= cfg_wr.word.size.size_i;
        job_cfg.size_j <= cfg_wr.word.size.size_j;
      end

      // One-cycle pulse to the controller
      start <= start_req;

      // Busy from accepted start until done
      if (start_req) begin
        busy <= 1'b1;
      end else if (done) begin
        busy <= 1'b0;
      end
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  // Controller finishes only a job that was started here
  done_while_busy: assert property (
    @(posedge CLK) disable iff (RST) done |-> busy
  );

endmodule

//--- hdl/ntm_sinh_pipeline.sv
// Three-stage fixed-point sinh Taylor evaluator with markers alongside

`timescale 1ns/1ps

module ntm_sinh_pipeline
  import ntm_math_pkg::*;
  import ntm_ctrl_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,
  input  logic      issue,
  input  sample_t   x,
  input  logic      row_end,
  input  logic      mat_end,
  output out_elem_t out_elem
);

  // Control bits that follow each element
  typedef struct packed {
    logic valid;
    logic last_col;
    logic last_row;
  } tag_t;

  tag_t    tag_1, tag_2, tag_3;
  sample_t x_1, x_2;
  wide_t   x2_1;
  wide_t   x3_2, x5_2;
  sample_t y_3;

  wide_t   x2_c, x3_c, x5_c;
  wide_t   t3_c, t5_c, sum_c;

  ////////////////////
  // Tag path
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      tag_1 <= '0;
      tag_2 <= '0;
      tag_3 <= '0;
    end else begin
      // Markers only count with a valid element
      tag_1 <= '{valid: issue, last_col: issue && row_end, last_row: issue && mat_end};
      tag_2 <= tag_1;
      tag_3 <= tag_2;
    end
  end

  ////////////////////
  // Arithmetic
  ////////////////////

  always_comb begin
    // Stage 1 square
    x2_c = (wide_t'(x) * wide_t'(x)) >>> FRAC_BITS;
    // Stage 2 odd powers, x5 built from this cycle's x3
    x3_c = (x2_1 * wide_t'(x_1)) >>> FRAC_BITS;
    x5_c = (x3_c * x2_1) >>> FRAC_BITS;
    // Stage 3 scaled terms and sum
    t3_c  = (x3_2 * C3) >>> FRAC_BITS;
    t5_c  = (x5_2 * C5) >>> FRAC_BITS;
    sum_c = wide_t'(x_2) + t3_c + t5_c;
  end

  always_ff @(posedge CLK) begin
    x_1  <= x;
    x2_1 <= x2_c;
    x_2  <= x_1;
    x3_2 <= x3_c;
    x5_2 <= x5_c;
    // Clamp to the Q4.12 range
    if (sum_c > wide_t'(SAMPLE_MAX)) begin
      y_3 <= SAMPLE_MAX;
    end else if (sum_c < wide_t'(SAMPLE_MIN)) begin
      y_3 <= SAMPLE_MIN;
    end else begin
      y_3 <= sample_t'(sum_c);
    end
  end

  assign out_elem = '{valid: tag_3.valid, data: y_3,
                      last_col: tag_3.last_col, last_row: tag_3.last_row};

endmodule

//--- hdl/ntm_matrix_sinh_function.sv
// Input buffer, row and column counters, credit accounting and issue control

`timescale 1ns/1ps

module ntm_matrix_sinh_function
  import ntm_math_pkg::*;
  import ntm_ctrl_pkg::*;
#(
  parameter int IN_DEPTH    = 4,
  parameter int OUT_CREDITS = 4
) (
  input  logic     CLK,
  input  logic     RST,
  input  logic     start,
  input  job_cfg_t job_cfg,
  input  in_elem_t in_elem,
  output logic     in_credit,
  input  logic     out_credit,
  output logic     issue,
  output sample_t  x,
  output logic     row_end,
  output logic     mat_end,
  output logic     done
);

  localparam int PTR_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
  localparam int CNT_W = $clog2(IN_DEPTH + 1);
  localparam int CRD_W = $clog2(OUT_CREDITS + 1);

  sample_t          buf_mem [IN_DEPTH];
  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CRD_W-1:0] credits;
  job_cfg_t         cfg_q;
  dim_t             row_idx, col_idx;
  logic [2:0]       mat_dly;

  ////////////////////
  // Issue decision
  ////////////////////

  // Buffered element and a free slot at the consumer
  assign issue     = (count != '0) && (credits != '0);
  assign in_credit = issue;
  assign x         = buf_mem[rd_ptr];

  // Markers from the indices of the issuing element
  assign row_end = issue && (col_idx == cfg_q.size_j - 8'd1);
  assign mat_end = row_end && (row_idx == cfg_q.size_i - 8'd1);

  ////////////////////
  // Input buffer
  ////////////////////

  // Storage only, occupancy lives in count
  always_ff @(posedge CLK) begin
    if (in_elem.valid) begin
      buf_mem[wr_ptr] <= in_elem.data;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Explicit wrap keeps a depth of one legal
      if (in_elem.valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (issue) begin
        rd_ptr <= (rd_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(in_elem.valid) - CNT_W'(issue);
    end
  end

  ////////////////////
  // Indices, credits
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      cfg_q   <= '0;
      row_idx <= '0;
      col_idx <= '0;
      credits <= CRD_W'(OUT_CREDITS);
      mat_dly <= '0;
    end else begin
      // New job, fresh dimensions and counters
      if (start) begin
        cfg_q   <= job_cfg;
        row_idx <= '0;
        col_idx <= '0;
      end else if (issue) begin
        if (row_end) begin
          col_idx <= '0;
          row_idx <= mat_end ? '0 : row_idx + 8'd1;
        end else begin
          col_idx <= col_idx + 8'd1;
        end
      end

      // Reserved at issue, returned by the consumer
      credits <= credits - CRD_W'(issue) + CRD_W'(out_credit);

      // Follows the three pipeline stages
      mat_dly <= {mat_dly[1:0], mat_end};
    end
  end

  assign done = mat_dly[2];

  ////////////////////
  // Checks
  ////////////////////

  // Producer stays within its credits, a same-cycle pop frees the slot
  no_write_when_full: assert property (
    @(posedge CLK) disable iff (RST)
    in_elem.valid |-> (count < CNT_W'(IN_DEPTH)) || issue
  );

  // Consumer returns no more than it was given
  credit_bound: assert property (
    @(posedge CLK) disable iff (RST) credits <= CRD_W'(OUT_CREDITS)
  );

endmodule

//--- hdl/ntm_matrix_sinh_top.sv
// Top level with configuration block, matrix controller and sinh pipeline

`timescale 1ns/1ps

module ntm_matrix_sinh_top
  import ntm_math_pkg::*;
  import ntm_ctrl_pkg::*;
#(
  parameter int IN_DEPTH    = 4,
  parameter int OUT_CREDITS = 4
) (
  input  logic      CLK,
  input  logic      RST,
  input  cfg_wr_t   cfg_wr,
  input  in_elem_t  in_elem,
  output logic      in_credit,
  input  logic      out_credit,
  output out_elem_t out_elem,
  output logic      done,
  output logic      busy
);

  job_cfg_t job_cfg;
  logic     start;
  logic     issue;
  sample_t  x;
  logic     row_end;
  logic     mat_end;

  // Register file and busy flag
  ntm_sinh_config ntm_sinh_config_inst (
    .CLK     (CLK),
    .RST     (RST),
    .cfg_wr  (cfg_wr),
    .done    (done),
    .job_cfg (job_cfg),
    .start   (start),
    .busy    (busy)
  );

  // Buffering, indices and credits
  ntm_matrix_sinh_function #(
    .IN_DEPTH    (IN_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
  ) ntm_matrix_sinh_function_inst (
    .CLK        (CLK),
    .RST        (RST),
    .start      (start),
    .job_cfg    (job_cfg),
    .in_elem    (in_elem),
    .in_credit  (in_credit),
    .out_credit (out_credit),
    .issue      (issue),
    .x          (x),
    .row_end    (row_end),
    .mat_end    (mat_end),
    .done       (done)
  );

  // Taylor evaluation, three cycles
  ntm_sinh_pipeline ntm_sinh_pipeline_inst (
    .CLK      (CLK),
    .RST      (RST),
    .issue    (issue),
    .x        (x),
    .row_end  (row_end),
    .mat_end  (mat_end),
    .out_elem (out_elem)
  );

endmodule

//--- verification/ntm_matrix_sinh_tb.sv
// Testbench with clock, reset, xorshift stimulus, sinh reference model, checks and timeout

`timescale 1ns/1ps

module ntm_matrix_sinh_tb
  import ntm_math_pkg::*;
  import ntm_ctrl_pkg::*;
();

  localparam int IN_DEPTH     = 4;
  localparam int OUT_CREDITS  = 4;
  localparam int NUM_JOBS     = 4;
  // Consumer holds its credits this long at the start of each job
  localparam int STALL_CYCLES = 30;

  logic      CLK;
  logic      RST;
  cfg_wr_t   cfg_wr;
  in_elem_t  in_elem;
  logic      in_credit;
  logic      out_credit;
  out_elem_t out_elem;
  logic      done;
  logic      busy;

  logic [31:0] rng_state;
  int          value_errors;
  int          protocol_errors;
  int          prod_credits;
  int          cycles;
  int          cycle_limit;
  dim_t        job_i [NUM_JOBS];
  dim_t        job_j [NUM_JOBS];
  out_elem_t   expected_q [$];

  ntm_matrix_sinh_top #(
    .IN_DEPTH    (IN_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
  ) ntm_matrix_sinh_top_inst (
    .CLK        (CLK),
    .RST        (RST),
    .cfg_wr     (cfg_wr),
    .in_elem    (in_elem),
    .in_credit  (in_credit),
    .out_credit (out_credit),
    .out_elem   (out_elem),
    .done       (done),
    .busy       (busy)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  ////////////////////
  // Stimulus and model
  ////////////////////

  function automatic logic [31:0] xorshift32();
    logic [31:0] s;
    s = rng_state;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    rng_state = s;
    return s;
  endfunction

  // Q4.12 value strictly inside +-2.0
  function automatic sample_t rand_sample();
    logic [31:0] r;
    int          v;
    r = xorshift32();
    // One draw in sixteen at the edge of the range
    if (r[3:0] == 4'd0) begin
      v = r[4] ? 8191 : -8191;
    end else begin
      v = int'(r[31:8] % 24'd16383) - 8191;
    end
    return sample_t'(v);
  endfunction

  // x + x^3/6 + x^5/120 with every product truncated by 12 bits
  function automatic sample_t sinh_model(input sample_t xin);
    wide_t xw, x2, x3, x5, sum;
    xw  = wide_t'(xin);
    x2  = (xw * xw) >>> 12;
    x3  = (x2 * xw) >>> 12;
    x5  = (x3 * x2) >>> 12;
    // 683 and 34 are 1/6 and 1/120 in Q12
    sum = xw + ((x3 * 683) >>> 12) + ((x5 * 34) >>> 12);
    if (sum > 32767) begin
      return 16'sh7FFF;
    end else if (sum < -32768) begin
      return 16'sh8000;
    end
    return sample_t'(sum);
  endfunction

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_elem(input string name, input out_elem_t exp, input out_elem_t act);
    if (act !== exp) begin
      $display("Fail %s: expected data %h col %b row %b, actual data %h col %b row %b",
               name, exp.data, exp.last_col, exp.last_row,
               act.data, act.last_col, act.last_row);
      value_errors++;
    end
  endtask

  task automatic check_done(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail %s done: expected %b, actual %b", name, exp, act);
      value_errors++;
    end
  endtask

  // Status bits such as busy and valid
  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail %s: expected %b, actual %b", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("Fail %s: expected %0d, actual %0d", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic note_error(input string msg);
    $display("Error: %s", msg);
    protocol_errors++;
  endtask

  ////////////////////
  // Bus tasks
  ////////////////////

  // Single-cycle register write starting on a falling edge
  task automatic write_cfg(input cfg_addr_t addr, input cfg_word_u word);
    cfg_wr.valid = 1'b1;
    cfg_wr.addr  = addr;
    cfg_wr.word  = word;
    @(negedge CLK);
    cfg_wr.valid = 1'b0;
  endtask

  // Quiet outputs while nothing runs
  task automatic idle_check(input string name, input int n);
    repeat (n) begin
      check_flag({name, " busy"}, 1'b0, busy);
      check_flag({name, " in_credit"}, 1'b0, in_credit);
      check_flag({name, " valid"}, 1'b0, out_elem.valid);
      check_done(name, 1'b0, done);
      @(negedge CLK);
    end
  endtask

  task automatic run_job(input int job, input dim_t si, input dim_t sj);
    cfg_word_u   word;
    out_elem_t   exp_e;
    logic [31:0] r;
    logic [2:0]  issue_hist;
    sample_t     v;
    string       name;
    int          sj_n, total, sent, received, dones, held, cyc;
    name       = $sformatf("job %0d (%0dx%0d)", job, si, sj);
    sj_n       = int'(sj);
    total      = int'(si) * sj_n;
    sent       = 0;
    received   = 0;
    dones      = 0;
    held       = 0;
    cyc        = 0;
    issue_hist = '0;
    expected_q.delete();
    word = '0;
    word.size.size_i = si;
    word.size.size_j = sj;
    write_cfg(ADDR_SIZE, word);
    word = '0;
    word.ctrl.start = 1'b1;
    write_cfg(ADDR_CTRL, word);
    cfg_wr.word = word;
    while (received < total || busy || held > 0) begin
      // Outputs have settled since the last rising edge
      // Busy holds from start until the cycle after done
      check_flag({name, " busy"}, dones == 0, busy);
      // An issue shows up as in_credit and leaves the pipeline three cycles later
      check_flag({name, " valid latency"}, issue_hist[2], out_elem.valid);
      issue_hist = {issue_hist[1:0], in_credit};
      if (in_credit) begin
        prod_credits++;
        if (prod_credits > IN_DEPTH) begin
          note_error($sformatf("%s returned more input credits than were spent", name));
        end
      end
      if (out_elem.valid) begin
        held++;
        if (held > OUT_CREDITS) begin
          note_error($sformatf("%s sent an output without an output credit", name));
        end
        if (expected_q.size() == 0) begin
          note_error($sformatf("%s sent more than its %0d elements", name, total));
          check_done(name, 1'b0, done);
        end else begin
          exp_e = expected_q.pop_front();
          check_elem($sformatf("%s element %0d", name, received), exp_e, out_elem);
          check_done(name, exp_e.last_row, done);
          received++;
        end
      end else begin
        check_done(name, 1'b0, done);
      end
      if (done) begin
        dones++;
      end
      // Credits return in random gaps once the stall is over
      r = xorshift32();
      out_credit = (cyc >= STALL_CYCLES) && (held > 0) && r[0];
      if (out_credit) begin
        held--;
      end
      // Producer sends on a credit in three draws of four
      r = xorshift32();
      if (busy && sent < total && prod_credits > 0 && r[1:0] != 2'd0) begin
        v = rand_sample();
        in_elem.valid  = 1'b1;
        in_elem.data   = v;
        exp_e.valid    = 1'b1;
        exp_e.data     = sinh_model(v);
        exp_e.last_col = (sent % sj_n) == sj_n - 1;
        exp_e.last_row = sent == total - 1;
        expected_q.push_back(exp_e);
        sent++;
        prod_credits--;
      end else begin
        in_elem.valid = 1'b0;
      end
      // A second start mid-job must be ignored
      cfg_wr.valid = (cyc == 6) && busy;
      @(negedge CLK);
      cyc++;
    end
    in_elem.valid = 1'b0;
    out_credit    = 1'b0;
    cfg_wr        = '0;
    check_count({name, " outputs"}, total, received);
    check_count({name, " done pulses"}, 1, dones);
    check_count({name, " producer credits"}, IN_DEPTH, prod_credits);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int total_elems;
    RST             = 1'b1;
    cfg_wr          = '0;
    in_elem         = '0;
    out_credit      = 1'b0;
    value_errors    = 0;
    protocol_errors = 0;
    prod_credits    = IN_DEPTH;
    rng_state       = 32'd1943;
    total_elems     = 0;
    // Dimensions up front so the cycle limit is known
    for (int k = 0; k < NUM_JOBS; k++) begin
      job_i[k] = dim_t'(1 + xorshift32() % 6);
      job_j[k] = dim_t'(1 + xorshift32() % 6);
      total_elems += int'(job_i[k]) * int'(job_j[k]);
    end
    cycle_limit = 64 * total_elems + 1000;
    repeat (8) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    idle_check("after reset", 8);
    for (int k = 0; k < NUM_JOBS; k++) begin
      run_job(k, job_i[k], job_j[k]);
      idle_check("between jobs", 3);
    end
    $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
    if (value_errors + protocol_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Cycle limit scales with the element count
  initial begin
    wait (cycle_limit > 0);
    while (cycles < cycle_limit) begin
      @(posedge CLK);
      cycles++;
    end
    $display("Error: run did not end within %0d cycles", cycle_limit);
    $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors + 1);
    $display("Finished with errors");
    $finish;
  end

endmodule

//--- tb.f
hdl/ntm_math_pkg.sv
hdl/ntm_ctrl_pkg.sv
hdl/ntm_sinh_config.sv
hdl/ntm_sinh_pipeline.sv
hdl/ntm_matrix_sinh_function.sv
hdl/ntm_matrix_sinh_top.sv
verification/ntm_matrix_sinh_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= ntm_matrix_sinh_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
